// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal
TOP       ?= tb_bc_core
FILELIST  ?= list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

// File: hdl/au_stack.sv
// arithmetic unit
// tos register over an operand stack, executes decoder commands
// idiv and irem go through the sequential divider
`timescale 1ns/1ps

module au_stack (
    input  logic                         ctl,
    input  logic                         arst_n,
    input  core_pkg::au_cmd_t            cmd,
    output logic                         div_bsy,
    output logic [core_pkg::DATA_W-1:0]  tos,
    output logic [core_pkg::DEPTH_W-1:0] depth
);

    logic [core_pkg::DATA_W-1:0]             stk [core_pkg::STACK_DEPTH];
    logic [core_pkg::DATA_W-1:0]             nos;
    logic [core_pkg::DATA_W-1:0]             push_val;
    logic [core_pkg::DATA_W-1:0]             tos_n;
    logic [core_pkg::DATA_W-1:0]             quotient;
    logic [core_pkg::DATA_W-1:0]             remainder;
    logic [core_pkg::DEPTH_W-1:0]            depth_n;
    logic [core_pkg::DEPTH_W-1:0]            depth_m1;
    logic [core_pkg::DEPTH_W-1:0]            depth_m2;
    logic [$clog2(core_pkg::STACK_DEPTH)-1:0] wr_idx;
    logic [7:0]                              const_val;
    logic                                    push;
    logic                                    stk_we;
    logic                                    div_go;
    logic                                    div_pend;
    logic                                    div_is_rem;

    assign depth_m1  = depth - 1'b1;
    assign depth_m2  = depth - 2'd2;
    assign nos       = stk[depth_m2[$clog2(core_pkg::STACK_DEPTH)-1:0]];
    assign const_val = cmd.op - jvm_op_pkg::iconst_0;   // -1..5

    always_comb begin
        push     = 1'b0;
        push_val = tos;   // dup
        tos_n    = tos;
        depth_n  = depth;
        stk_we   = 1'b0;
        wr_idx   = depth_m1[$clog2(core_pkg::STACK_DEPTH)-1:0];
        div_go   = 1'b0;
        if (div_pend && !div_bsy) begin
            tos_n   = div_is_rem ? remainder : quotient;
            depth_n = depth_m1;
        end else if (cmd.en) begin
            case (cmd.op)
                jvm_op_pkg::iconst_m1, jvm_op_pkg::iconst_0, jvm_op_pkg::iconst_1,
                jvm_op_pkg::iconst_2, jvm_op_pkg::iconst_3, jvm_op_pkg::iconst_4,
                jvm_op_pkg::iconst_5: begin
                    push     = 1'b1;
                    push_val = {{(core_pkg::DATA_W-8){const_val[7]}}, const_val};
                end
                jvm_op_pkg::bipush: begin
                    push     = 1'b1;
                    push_val = {{(core_pkg::DATA_W-8){cmd.imm[7]}}, cmd.imm[7:0]};
                end
                jvm_op_pkg::sipush: begin
                    push     = 1'b1;
                    push_val = {{(core_pkg::DATA_W-16){cmd.imm[15]}}, cmd.imm};
                end
                jvm_op_pkg::dup: push = 1'b1;
                jvm_op_pkg::pop: begin
                    tos_n   = nos;
                    depth_n = depth_m1;
                end
                jvm_op_pkg::swap: begin
                    tos_n  = nos;
                    stk_we = 1'b1;
                    wr_idx = depth_m2[$clog2(core_pkg::STACK_DEPTH)-1:0];
                end
                jvm_op_pkg::iadd: begin
                    tos_n   = nos + tos;
                    depth_n = depth_m1;
                end
                jvm_op_pkg::isub: begin
                    tos_n   = nos - tos;
                    depth_n = depth_m1;
                end
                jvm_op_pkg::imul: begin
                    tos_n   = nos * tos;   // low word only
                    depth_n = depth_m1;
                end
                jvm_op_pkg::iand: begin
                    tos_n   = nos & tos;
                    depth_n = depth_m1;
                end
                jvm_op_pkg::ior: begin
                    tos_n   = nos | tos;
                    depth_n = depth_m1;
                end
                jvm_op_pkg::ixor: begin
                    tos_n   = nos ^ tos;
                    depth_n = depth_m1;
                end
                jvm_op_pkg::ineg: tos_n = -tos;
                jvm_op_pkg::idiv, jvm_op_pkg::irem: div_go = 1'b1;
                default: ;
            endcase
            if (push) begin
                tos_n   = push_val;
                depth_n = depth + 1'b1;
                stk_we  = (depth != '0);   // old tos goes below
            end
        end
    end

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            tos        <= '0;
            depth      <= '0;
            div_pend   <= 1'b0;
            div_is_rem <= 1'b0;
        end else begin
            tos   <= tos_n;
            depth <= depth_n;
            if (div_go) begin
                div_pend   <= 1'b1;
                div_is_rem <= (cmd.op == jvm_op_pkg::irem);
            end else if (!div_bsy) begin
                div_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge ctl) begin
        if (stk_we) begin
            stk[wr_idx] <= tos;
        end
    end

    seq_divider div_i (
        .ctl       (ctl),
        .arst_n    (arst_n),
        .start     (div_go),
        .dividend  (nos),
        .divisor   (tos),
        .quotient  (quotient),
        .remainder (remainder),
        .busy      (div_bsy)
    );

    // decoder must not issue an operator the stack cannot feed
    assert property (@(posedge ctl) disable iff (!arst_n)
        cmd.en && (cmd.op inside {jvm_op_pkg::iadd, jvm_op_pkg::isub, jvm_op_pkg::imul,
            jvm_op_pkg::iand, jvm_op_pkg::ior, jvm_op_pkg::ixor, jvm_op_pkg::swap,
            jvm_op_pkg::idiv, jvm_op_pkg::irem}) |-> depth >= 2)
        else $error("stack underflow, two operands needed");

    assert property (@(posedge ctl) disable iff (!arst_n)
        cmd.en && (cmd.op inside {jvm_op_pkg::pop, jvm_op_pkg::dup, jvm_op_pkg::ineg})
            |-> depth != '0)
        else $error("stack underflow, empty stack");

    assert property (@(posedge ctl) disable iff (!arst_n)
        push |-> depth <= core_pkg::STACK_DEPTH)
        else $error("stack overflow on push");

endmodule

// File: hdl/bc_cfg_regs.sv
// configuration registers
// cold-start address at 0, run bit at 1
`timescale 1ns/1ps

module bc_cfg_regs (
    input  logic                        ctl,
    input  logic                        arst_n,
    input  logic                        cfg_wr,
    input  logic                        cfg_addr,
    input  logic [core_pkg::ADDR_W-1:0] cfg_wdata,
    output core_pkg::cfg_t              cfg
);

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            cfg.cold_addr <= '0;
            cfg.run       <= 1'b0;
        end else if (cfg_wr) begin
            if (cfg_addr) begin
                cfg.run <= cfg_wdata[0];
            end else begin
                cfg.cold_addr <= cfg_wdata;
            end
        end
    end

    // a write with an unknown address would hit either register
    assert property (@(posedge ctl) disable iff (!arst_n)
        cfg_wr |-> !$isunknown(cfg_addr))
        else $error("config write with unknown address");

endmodule

// File: hdl/bc_core_top.sv
// bytecode core top
// config block, decoder and stack unit, status gathered for the outside
`timescale 1ns/1ps

module bc_core_top (
    input  logic                        ctl,
    input  logic                        arst_n,
    input  logic                        cfg_wr,
    input  logic                        cfg_addr,
    input  logic [core_pkg::ADDR_W-1:0] cfg_wdata,
    input  logic [7:0]                  code_byte,
    output logic [core_pkg::ADDR_W-1:0] pc,
    output core_pkg::core_status_t      status
);

    core_pkg::cfg_t               cfg;
    core_pkg::au_cmd_t            cmd;
    logic                         div_bsy;
    logic                         halted;
    logic [core_pkg::DATA_W-1:0]  tos;
    logic [core_pkg::DEPTH_W-1:0] depth;

    bc_cfg_regs cfg_i (
        .ctl       (ctl),
        .arst_n    (arst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    bc_decoder dec_i (
        .ctl       (ctl),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .code_byte (code_byte),
        .div_bsy   (div_bsy),
        .pc        (pc),
        .cmd       (cmd),
        .halted    (halted)
    );

    au_stack au_i (
        .ctl     (ctl),
        .arst_n  (arst_n),
        .cmd     (cmd),
        .div_bsy (div_bsy),
        .tos     (tos),
        .depth   (depth)
    );

    assign status.pc      = pc;
    assign status.tos     = tos;
    assign status.depth   = depth;
    assign status.halted  = halted;
    assign status.div_bsy = div_bsy;

endmodule

// File: hdl/bc_decoder.sv
// bytecode decoder
// phase sequencing per opcode, pc stepping and the command to the stack unit
`timescale 1ns/1ps

module bc_decoder (
    input  logic                        ctl,
    input  logic                        arst_n,
    input  core_pkg::cfg_t              cfg,
    input  logic [7:0]                  code_byte,
    input  logic                        div_bsy,
    output logic [core_pkg::ADDR_W-1:0] pc,
    output core_pkg::au_cmd_t           cmd,
    output logic                        halted
);

    jvm_op_pkg::phase_t  phase_q;
    jvm_op_pkg::phase_t  phase_n;
    jvm_op_pkg::opcode_t op_q;
    jvm_op_pkg::opcode_t byte_op;
    jvm_op_pkg::opcode_t cur_op;
    logic [7:0]          imm_q;
    logic                en;
    logic                op_ld;
    logic                pc_inc;
    logic                stop;

    // anything outside the supported set becomes op_err
    always_comb begin
        case (code_byte)
            jvm_op_pkg::nop, jvm_op_pkg::iconst_m1, jvm_op_pkg::iconst_0,
            jvm_op_pkg::iconst_1, jvm_op_pkg::iconst_2, jvm_op_pkg::iconst_3,
            jvm_op_pkg::iconst_4, jvm_op_pkg::iconst_5, jvm_op_pkg::bipush,
            jvm_op_pkg::sipush, jvm_op_pkg::pop, jvm_op_pkg::dup, jvm_op_pkg::swap,
            jvm_op_pkg::iadd, jvm_op_pkg::isub, jvm_op_pkg::imul, jvm_op_pkg::idiv,
            jvm_op_pkg::irem, jvm_op_pkg::ineg, jvm_op_pkg::iand, jvm_op_pkg::ior,
            jvm_op_pkg::ixor, jvm_op_pkg::halt:
                byte_op = jvm_op_pkg::opcode_t'(code_byte);
            default:
                byte_op = jvm_op_pkg::op_err;
        endcase
    end

    // opcode is on the bus in phase 0, held in op_q after that
    assign cur_op = (phase_q == '0) ? byte_op : op_q;

    always_comb begin
        en      = 1'b0;
        phase_n = '0;
        op_ld   = (phase_q == '0);
        pc_inc  = 1'b1;   // take a byte by default
        stop    = 1'b0;
        case (cur_op)
            jvm_op_pkg::bipush: begin
                if (phase_q == '0) begin
                    phase_n = 3'd1;
                end else begin
                    en = 1'b1;   // operand byte on the bus now
                end
            end
            jvm_op_pkg::sipush: begin
                case (phase_q)
                    3'd0:    phase_n = 3'd1;
                    3'd1:    phase_n = 3'd2;   // high byte into imm_q
                    default: en = 1'b1;
                endcase
            end
            jvm_op_pkg::idiv, jvm_op_pkg::irem: begin
                pc_inc  = 1'b0;
                phase_n = 3'd1;
                if (phase_q == '0) begin
                    en = 1'b1;   // starts the divider
                end else if (!div_bsy) begin
                    pc_inc  = 1'b1;
                    phase_n = '0;
                end
            end
            jvm_op_pkg::halt, jvm_op_pkg::op_err: begin
                pc_inc = 1'b0;
                stop   = 1'b1;
            end
            default: en = 1'b1;
        endcase
        if (!cfg.run || halted) begin
            en = 1'b0;
        end
    end

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            phase_q <= '0;
            op_q    <= jvm_op_pkg::nop;
            pc      <= '0;
            halted  <= 1'b0;
        end else if (!cfg.run) begin
            phase_q <= '0;
            op_q    <= jvm_op_pkg::nop;
            pc      <= cfg.cold_addr;   // parked until run
            halted  <= 1'b0;
        end else if (!halted) begin
            phase_q <= phase_n;
            if (op_ld) begin
                op_q <= cur_op;
            end
            if (pc_inc) begin
                pc <= pc + 1'b1;
            end
            if (stop) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge ctl) begin
        if (pc_inc) begin
            imm_q <= code_byte;
        end
    end

    assign cmd.en  = en;
    assign cmd.op  = cur_op;
    assign cmd.imm = {imm_q, code_byte};

    // only multi-cycle opcodes leave phase 0 and only sipush reaches phase 2
    assert property (@(posedge ctl) disable iff (!arst_n)
        (phase_q != '0) |-> (op_q inside {jvm_op_pkg::bipush, jvm_op_pkg::sipush,
            jvm_op_pkg::idiv, jvm_op_pkg::irem})
            && ((phase_q == 3'd1) || (op_q == jvm_op_pkg::sipush && phase_q == 3'd2)))
        else $error("decoder phase overrun");

endmodule

// File: hdl/core_pkg.sv
// core-wide widths and the structs passed between the front end and the stack unit
package core_pkg;

    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 16;
    localparam int STACK_DEPTH = 8;   // entries below tos
    localparam int DEPTH_W     = 4;   // counts 0..STACK_DEPTH+1

    // decoder to arithmetic unit
    typedef struct packed {
        logic                en;
        jvm_op_pkg::opcode_t op;
        logic [15:0]         imm;   // operand bytes, latest in the low byte
    } au_cmd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] cold_addr;
        logic              run;
    } cfg_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  pc;
        logic [DATA_W-1:0]  tos;
        logic [DEPTH_W-1:0] depth;
        logic               halted;
        logic               div_bsy;
    } core_status_t;

endpackage

// File: hdl/jvm_op_pkg.sv
// jvm opcode set
// byte values of the supported bytecodes and the in-instruction phase type
package jvm_op_pkg;

    typedef enum logic [7:0] {
        nop       = 8'h00,
        iconst_m1 = 8'h02,
        iconst_0  = 8'h03,   // iconst_n = iconst_0 + n
        iconst_1  = 8'h04,
        iconst_2  = 8'h05,
        iconst_3  = 8'h06,
        iconst_4  = 8'h07,
        iconst_5  = 8'h08,
        bipush    = 8'h10,   // one operand byte
        sipush    = 8'h11,   // two operand bytes, high first
        pop       = 8'h57,
        dup       = 8'h59,
        swap      = 8'h5F,
        iadd      = 8'h60,
        isub      = 8'h64,
        imul      = 8'h68,
        idiv      = 8'h6C,
        irem      = 8'h70,
        ineg      = 8'h74,
        iand      = 8'h7E,
        ior       = 8'h80,
        ixor      = 8'h82,
        // internal only, any undecodable byte maps here
        op_err    = 8'hFE,
        halt      = 8'hFF
    } opcode_t;

    // cycle index inside a multi-byte or multi-cycle instruction
    typedef logic [2:0] phase_t;

endpackage

// File: hdl/seq_divider.sv
// signed restoring divider, one quotient bit per clock
// java semantics, quotient toward zero, remainder follows dividend sign
`timescale 1ns/1ps

module seq_divider (
    input  logic                        ctl,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic [core_pkg::DATA_W-1:0] dividend,
    input  logic [core_pkg::DATA_W-1:0] divisor,
    output logic [core_pkg::DATA_W-1:0] quotient,
    output logic [core_pkg::DATA_W-1:0] remainder,
    output logic                        busy
);

    logic [core_pkg::DATA_W-1:0]         q_sr;      // dividend bits out, quotient bits in
    logic [core_pkg::DATA_W-1:0]         rem_mag;
    logic [core_pkg::DATA_W-1:0]         dvs_mag;
    logic [core_pkg::DATA_W:0]           trial;
    logic [$clog2(core_pkg::DATA_W)-1:0] cnt;
    logic                                q_neg;
    logic                                r_neg;

    assign trial = {rem_mag, q_sr[core_pkg::DATA_W-1]} - {1'b0, dvs_mag};

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == core_pkg::DATA_W - 1) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge ctl) begin
        if (start) begin
            q_sr    <= dividend[core_pkg::DATA_W-1] ? -dividend : dividend;
            dvs_mag <= divisor[core_pkg::DATA_W-1] ? -divisor : divisor;
            rem_mag <= '0;
            // zero divisor keeps the all-ones quotient unsigned
            q_neg   <= (dividend[core_pkg::DATA_W-1] ^ divisor[core_pkg::DATA_W-1])
                       && (divisor != '0);
            r_neg   <= dividend[core_pkg::DATA_W-1];
        end else if (busy) begin
            if (trial[core_pkg::DATA_W]) begin   // borrow, restore
                rem_mag <= {rem_mag[core_pkg::DATA_W-2:0], q_sr[core_pkg::DATA_W-1]};
                q_sr    <= {q_sr[core_pkg::DATA_W-2:0], 1'b0};
            end else begin
                rem_mag <= trial[core_pkg::DATA_W-1:0];
                q_sr    <= {q_sr[core_pkg::DATA_W-2:0], 1'b1};
            end
        end
    end

    assign quotient  = q_neg ? -q_sr : q_sr;
    assign remainder = r_neg ? -rem_mag : rem_mag;

    assert property (@(posedge ctl) disable iff (!arst_n)
        start |-> !busy)
        else $error("divider restarted while busy");

endmodule

// File: list.f
hdl/jvm_op_pkg.sv
hdl/core_pkg.sv
hdl/bc_cfg_regs.sv
hdl/seq_divider.sv
hdl/bc_decoder.sv
hdl/au_stack.sv
hdl/bc_core_top.sv
tb/tb_bc_core.sv

// File: tb/tb_bc_core.sv
// testbench for the bytecode core
// byte ROM, random program generator, reference interpreter and watchdog
`timescale 1ns/1ps

module tb_bc_core;

    localparam jvm_op_pkg::opcode_t bin_ops [7] = '{jvm_op_pkg::swap, jvm_op_pkg::iadd,
        jvm_op_pkg::isub, jvm_op_pkg::imul, jvm_op_pkg::iand, jvm_op_pkg::ior, jvm_op_pkg::ixor};

    logic                        ctl = 1'b0;
    logic                        arst_n;
    logic                        cfg_wr;
    logic                        cfg_addr;
    logic [core_pkg::ADDR_W-1:0] cfg_wdata;
    logic [7:0]                  code_byte;
    logic [core_pkg::ADDR_W-1:0] pc;
    core_pkg::core_status_t      status;

    logic [7:0]  rom [65536];
    logic [7:0]  prog [$];
    logic [31:0] mstk [$];   // model stack, top at the back
    int unsigned seed = 34801;
    int          budget = 400;   // cycles, grows with every program
    int          busy_len;

    always #20 ctl = ~ctl;

    assign code_byte = rom[pc];

    bc_core_top dut_i (
        .ctl       (ctl),
        .arst_n    (arst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .code_byte (code_byte),
        .pc        (pc),
        .status    (status)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
            else abort_run($sformatf("Fail %s expected %0h actual %0h", name, exp, act));
    endtask

    function automatic int unsigned rand_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    // java rules, truncate toward zero, remainder keeps the dividend sign
    function automatic logic [31:0] java_div(input logic [31:0] n, input logic [31:0] dv,
                                             input bit rem);
        longint a;
        longint b;
        a = longint'($signed(n));
        b = longint'($signed(dv));
        if (dv == '0) begin
            return rem ? n : 32'hFFFF_FFFF;
        end
        return rem ? 32'(a % b) : 32'(a / b);
    endfunction

    always @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            busy_len <= 0;
        end else begin
            busy_len <= status.div_bsy ? busy_len + 1 : 0;
        end
    end

    assert property (@(posedge ctl) disable iff (!arst_n) status.div_bsy |=> $stable(pc))
        else abort_run("pc moved while the divider was busy");

    assert property (@(posedge ctl) disable iff (!arst_n)
        $fell(status.div_bsy) |-> busy_len == core_pkg::DATA_W)
        else abort_run($sformatf("Fail div_busy_len expected %0d actual %0d",
                                 core_pkg::DATA_W, $sampled(busy_len)));

    // walks the ROM from base and updates the model stack
    task automatic interpret(input int base, output int end_pc);
        int          p;
        logic [7:0]  b;
        logic [31:0] a;
        logic [31:0] c;
        logic [31:0] r;
        bit          done;
        p = base;
        done = 1'b0;
        while (!done) begin
            b = rom[p];
            case (b)
                jvm_op_pkg::nop: p++;
                jvm_op_pkg::iconst_m1, jvm_op_pkg::iconst_0, jvm_op_pkg::iconst_1,
                jvm_op_pkg::iconst_2, jvm_op_pkg::iconst_3, jvm_op_pkg::iconst_4,
                jvm_op_pkg::iconst_5: begin
                    mstk.push_back(32'(int'(b) - 3));
                    p++;
                end
                jvm_op_pkg::bipush: begin
                    mstk.push_back({{24{rom[p + 1][7]}}, rom[p + 1]});
                    p += 2;
                end
                jvm_op_pkg::sipush: begin
                    mstk.push_back({{16{rom[p + 1][7]}}, rom[p + 1], rom[p + 2]});
                    p += 3;
                end
                jvm_op_pkg::pop: begin
                    a = mstk.pop_back();
                    p++;
                end
                jvm_op_pkg::dup: begin
                    mstk.push_back(mstk[$]);
                    p++;
                end
                jvm_op_pkg::ineg: begin
                    a = mstk.pop_back();
                    mstk.push_back(-a);
                    p++;
                end
                jvm_op_pkg::swap, jvm_op_pkg::iadd, jvm_op_pkg::isub, jvm_op_pkg::imul,
                jvm_op_pkg::iand, jvm_op_pkg::ior, jvm_op_pkg::ixor, jvm_op_pkg::idiv,
                jvm_op_pkg::irem: begin
                    a = mstk.pop_back();   // old tos
                    c = mstk.pop_back();
                    case (b)
                        jvm_op_pkg::swap: begin
                            mstk.push_back(a);
                            r = c;
                        end
                        jvm_op_pkg::iadd: r = c + a;
                        jvm_op_pkg::isub: r = c - a;
                        jvm_op_pkg::imul: r = c * a;
                        jvm_op_pkg::iand: r = c & a;
                        jvm_op_pkg::ior:  r = c | a;
                        jvm_op_pkg::idiv: r = java_div(c, a, 1'b0);
                        jvm_op_pkg::irem: r = java_div(c, a, 1'b1);
                        default:          r = c ^ a;
                    endcase
                    mstk.push_back(r);
                    p++;
                end
                default: done = 1'b1;   // halt or unsupported byte
            endcase
        end
        end_pc = p;
    endtask

    // keeps the depth inside 0..STACK_DEPTH+1, always ends in halt
    task automatic gen_program(input int base, input int n_ops, input bit with_div);
        int          a;
        int          d;
        int          k;
        int unsigned v;
        int unsigned w;
        a = base;
        d = mstk.size();
        repeat (n_ops) begin
            k = int'(rand_next() % 4);
            v = rand_next();
            w = rand_next();
            if (k == 3 && !with_div) k = 2;
            if (d < 2 && k > d) k = d;   // too shallow for operators
            if (d > core_pkg::STACK_DEPTH && k == 0) k = 2;
            case (k)
                0: begin
                    d++;
                    if (v % 4 == 0) begin
                        rom[a] = jvm_op_pkg::bipush;
                        rom[a + 1] = w[7:0];
                        a += 2;
                    end else if (v % 4 == 1) begin
                        rom[a] = jvm_op_pkg::sipush;
                        rom[a + 1] = w[15:8];
                        rom[a + 2] = w[7:0];
                        a += 3;
                    end else begin
                        rom[a] = 8'(int'(jvm_op_pkg::iconst_m1) + int'(w % 7));
                        a++;
                    end
                end
                1: begin
                    if (v % 3 == 0) begin
                        rom[a] = jvm_op_pkg::pop;
                        d--;
                    end else if (v % 3 == 1 && d <= core_pkg::STACK_DEPTH) begin
                        rom[a] = jvm_op_pkg::dup;
                        d++;
                    end else begin
                        rom[a] = jvm_op_pkg::ineg;
                    end
                    a++;
                end
                2: begin
                    rom[a] = bin_ops[v % 7];
                    if (rom[a] != jvm_op_pkg::swap) d--;
                    a++;
                end
                default: begin
                    rom[a] = (v % 2 == 0) ? jvm_op_pkg::idiv : jvm_op_pkg::irem;
                    d--;
                    a++;
                end
            endcase
        end
        rom[a] = jvm_op_pkg::halt;
    endtask

    task automatic cfg_write(input logic addr, input logic [15:0] data);
        @(posedge ctl);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge ctl);
        cfg_wr <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge ctl);
        arst_n <= 1'b0;
        repeat (10) @(posedge ctl);
        arst_n <= 1'b1;
        @(negedge ctl);
        mstk.delete();
    endtask

    // restart from base and compare the halt state with the model
    task automatic run_case(input string name, input int base);
        int          end_pc;
        logic [31:0] depth_before;
        depth_before = mstk.size();
        interpret(base, end_pc);
        budget += (end_pc - base + 1) * (core_pkg::DATA_W + 4) + 16;
        cfg_write(1'b1, 16'h0);
        cfg_write(1'b0, base[15:0]);
        cfg_write(1'b1, 16'h1);
        @(negedge ctl);
        check_val({name, " start pc"}, base, 32'(status.pc));
        check_val({name, " start depth"}, depth_before, 32'(status.depth));
        while (!status.halted) @(negedge ctl);
        check_val({name, " halt pc"}, end_pc, 32'(status.pc));
        check_val({name, " depth"}, mstk.size(), 32'(status.depth));
        if (mstk.size() > 0) check_val({name, " tos"}, mstk[$], status.tos);
    endtask

    task automatic run_bytes(input string name, input int base);
        foreach (prog[j]) rom[base + j] = prog[j];
        run_case(name, base);
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < budget) begin
            @(posedge ctl);
            cycles++;
        end
        abort_run($sformatf("watchdog expired after %0d cycles", cycles));
    end

    initial begin
        int i;
        arst_n    = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = 1'b0;
        cfg_wdata = '0;
        for (i = 0; i < 65536; i++) rom[i] = 8'(i ^ (i >> 8));
        apply_reset();
        check_val("reset halted", 0, 32'(status.halted));
        check_val("reset depth", 0, 32'(status.depth));
        check_val("reset div_bsy", 0, 32'(status.div_bsy));
        repeat (3) begin
            @(negedge ctl);
            check_val("parked pc", 0, 32'(pc));
        end
        cfg_write(1'b0, 16'h4321);
        @(posedge ctl);   // pc reloads from cold_addr one edge after the write
        repeat (4) begin
            @(negedge ctl);
            check_val("parked pc new cold_addr", 32'h4321, 32'(pc));
        end

        // all constants, bipush -100, sipush -12345, then operators down to depth 4
        prog = '{8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08, 8'h10, 8'h9C, 8'h11,
                 8'hCF, 8'hC7, 8'h60, 8'h64, 8'h5F, 8'h57, 8'h59, 8'h68, 8'h7E, 8'h80,
                 8'h74, 8'hFF};
        run_bytes("const_mix", 16'h0100);
        for (i = 0; i < 12; i++) begin
            gen_program(16'h1000 + i * 256, 6 + int'(rand_next() % 16), 1'b0);
            run_case($sformatf("rand_%0d", i), 16'h1000 + i * 256);
        end

        apply_reset();
        prog = '{8'h11, 8'hFC, 8'h18, 8'h10, 8'h07, 8'h6C, 8'hFF};   // -1000 / 7
        run_bytes("div_neg", 16'h2000);
        prog = '{8'h11, 8'hFC, 8'h18, 8'h10, 8'h07, 8'h70, 8'hFF};
        run_bytes("rem_neg", 16'h2010);
        prog = '{8'h10, 8'hF9, 8'h03, 8'h6C, 8'hFF};   // -7 / 0
        run_bytes("div_zero", 16'h2020);
        prog = '{8'h10, 8'hF9, 8'h03, 8'h70, 8'hFF};
        run_bytes("rem_zero", 16'h2030);
        prog = '{8'h10, 8'h64, 8'h10, 8'hF9, 8'h6C, 8'hFF};   // 100 / -7
        run_bytes("div_pos_neg", 16'h2040);
        prog = '{8'h10, 8'h64, 8'h10, 8'hF9, 8'h70, 8'hFF};
        run_bytes("rem_pos_neg", 16'h2050);
        for (i = 0; i < 6; i++) begin
            gen_program(16'h2100 + i * 256, 6 + int'(rand_next() % 10), 1'b1);
            run_case($sformatf("rand_div_%0d", i), 16'h2100 + i * 256);
        end

        // 0x01 is outside the supported set, second run restarts with the stack kept
        apply_reset();
        prog = '{8'h04, 8'h05, 8'h01, 8'hFF};
        run_bytes("bad_byte", 16'h3000);
        run_case("bad_byte_restart", 16'h3000);

        $display("NO ERRORS");
        $finish;
    end

endmodule
